// ==== design/core_ctrl_pkg.sv ====
// Status word layout, menu enums, settings struct and SD pin struct
package core_ctrl_pkg;

   // ============================================================
   // Menu status word
   // ============================================================
   localparam int STATUS_W = 64;

   // Bit positions, multi-bit fields give their lowest bit
   localparam int ST_RESET    = 0;
   localparam int ST_ASPECT   = 1;   // bits 2..1
   localparam int ST_FX       = 3;   // bits 5..3
   localparam int ST_SCALE    = 6;   // bits 7..6
   localparam int ST_TAPE_SRC = 8;
   localparam int ST_REWIND   = 9;
   localparam int ST_DETACH   = 10;
   localparam int ST_VCROP    = 40;

   // ============================================================
   // Menu choices
   // ============================================================
   typedef enum logic [1:0] {
      ASPECT_ORIGINAL = 2'd0,
      ASPECT_FULL     = 2'd1,
      ASPECT_CUSTOM1  = 2'd2,
      ASPECT_CUSTOM2  = 2'd3
   } aspect_e;

   // Scandoubler effect, CRT entries carry the scanline level
   typedef enum logic [2:0] {
      FX_NONE     = 3'd0,
      FX_HQ2X_320 = 3'd1,
      FX_HQ2X_160 = 3'd2,
      FX_CRT25    = 3'd3,
      FX_CRT50    = 3'd4,
      FX_CRT75    = 3'd5
   } fx_e;

   typedef enum logic {
      TAPE_SRC_FILE = 1'b0,
      TAPE_SRC_ADC  = 1'b1
   } tape_src_e;

   // Decoded settings for the video and tape sides
   typedef struct packed {
      aspect_e    aspect;
      fx_e        fx;
      logic [1:0] scale;
      logic       vcrop_en;
      tape_src_e  tape_src;
      logic       rewind_req;
      logic       scandoubler;
   } osd_settings_t;

   // SD card SPI pins
   typedef struct packed {
      logic sck;
      logic mosi;
      logic cs;
   } sd_pins_t;

   // Download slot of cassette images
   localparam logic [5:0] CAS_INDEX = 6'd5;

endpackage

// ==== design/display_pkg.sv ====
// Video geometry types, crop rule tables and aspect ratio constants
package display_pkg;

   typedef logic [11:0] dim_t;

   // One HDMI height and the number of source lines shown on it
   typedef struct packed {
      dim_t height;
      dim_t lines;
      logic wide_ok;
   } crop_rule_t;

   // ============================================================
   // Crop tables
   // ============================================================
   localparam int WIDE_RULES = 7;
   localparam int TALL_RULES = 2;

   // Modes at least 1.5 times wider than high
   localparam crop_rule_t WIDE_CROP_RULES [WIDE_RULES] = '{
      '{12'd480,  12'd240, 1'b0},
      '{12'd600,  12'd200, 1'b1},
      '{12'd720,  12'd240, 1'b0},
      '{12'd768,  12'd256, 1'b0},   // NTSC shows only 250 lines here
      '{12'd800,  12'd200, 1'b1},
      '{12'd1080, 12'd216, 1'b0},
      '{12'd1200, 12'd240, 1'b0}
   };

   // 4:3 modes that miss the wide test
   localparam crop_rule_t TALL_CROP_RULES [TALL_RULES] = '{
      '{12'd1440, 12'd240, 1'b0},
      '{12'd1536, 12'd256, 1'b0}
   };

   localparam dim_t TALL_MIN_WIDTH = 12'd1440;

   // Aspect ratio pairs
   localparam dim_t ARX_ORIGINAL = 12'd3;
   localparam dim_t ARX_NORMAL   = 12'd400;
   localparam dim_t ARX_WIDE     = 12'd340;
   localparam dim_t ARY_NORMAL   = 12'd300;

   typedef struct packed {
      dim_t       arx;
      dim_t       ary;
      dim_t       crop_size;
      logic [2:0] scale;
      logic [1:0] vga_sl;
      logic       hq2x;
      logic       scandoubler;
   } video_geom_t;

endpackage

// ==== design/msx_core_ctrl.sv ====
// MSX core control top level with status decode, video geometry, SD and tape blocks
module msx_core_ctrl #(
   parameter int ACT_TIMEOUT = 1_000_000
) (
   input  logic                                clock_bus,
   input  logic                                rst_n,
   input  logic [core_ctrl_pkg::STATUS_W-1:0]  status,
   input  logic                                ext_reset,
   input  logic                                forced_scandoubler,
   input  display_pkg::dim_t                   hdmi_width,
   input  display_pkg::dim_t                   hdmi_height,
   input  logic                                img_mounted,
   input  logic [63:0]                         img_size,
   input  logic                                spi_sck,
   input  logic                                spi_mosi,
   input  logic                                card_miso,
   input  logic                                virt_miso,
   input  logic                                ioctl_download,
   input  logic [5:0]                          ioctl_index,
   input  logic                                tape_file,
   input  logic                                tape_adc,
   input  logic                                tape_adc_act,
   output logic                                core_reset,
   output display_pkg::video_geom_t            geom,
   output core_ctrl_pkg::sd_pins_t             sd_pins,
   output logic                                spi_miso,
   output logic                                led_user,
   output logic [1:0]                          led_disk,
   output logic                                cas_play,
   output logic                                cas_rewind,
   output logic                                tape_audio
);

   core_ctrl_pkg::osd_settings_t settings;

   // ============================================================
   // Menu and video
   // ============================================================
   status_decode u_status_decode (
      .clock_bus          (clock_bus),
      .rst_n              (rst_n),
      .status             (status),
      .ext_reset          (ext_reset),
      .forced_scandoubler (forced_scandoubler),
      .settings           (settings),
      .core_reset         (core_reset)
   );

   video_geometry u_video_geometry (
      .clock_bus   (clock_bus),
      .rst_n       (rst_n),
      .settings    (settings),
      .hdmi_width  (hdmi_width),
      .hdmi_height (hdmi_height),
      .geom        (geom)
   );

   // ============================================================
   // SD card and cassette
   // ============================================================
   sd_activity #(
      .ACT_TIMEOUT (ACT_TIMEOUT)
   ) u_sd_activity (
      .clock_bus   (clock_bus),
      .rst_n       (rst_n),
      .img_mounted (img_mounted),
      .img_size    (img_size),
      .spi_sck     (spi_sck),
      .spi_mosi    (spi_mosi),
      .card_miso   (card_miso),
      .virt_miso   (virt_miso),
      .sd_pins     (sd_pins),
      .spi_miso    (spi_miso),
      .led_user    (led_user),
      .led_disk    (led_disk)
   );

   tape_control u_tape_control (
      .clock_bus      (clock_bus),
      .rst_n          (rst_n),
      .settings       (settings),
      .core_reset     (core_reset),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .tape_file      (tape_file),
      .tape_adc       (tape_adc),
      .tape_adc_act   (tape_adc_act),
      .cas_play       (cas_play),
      .cas_rewind     (cas_rewind),
      .tape_audio     (tape_audio)
   );

endmodule

// ==== design/sd_activity.sv ====
// Virtual or physical SD card select, SPI pin gating and activity LEDs
module sd_activity #(
   parameter int ACT_TIMEOUT = 1_000_000
) (
   input  logic                    clock_bus,
   input  logic                    rst_n,
   input  logic                    img_mounted,
   input  logic [63:0]             img_size,
   input  logic                    spi_sck,
   input  logic                    spi_mosi,
   input  logic                    card_miso,
   input  logic                    virt_miso,
   output core_ctrl_pkg::sd_pins_t sd_pins,
   output logic                    spi_miso,
   output logic                    led_user,
   output logic [1:0]              led_disk
);

   localparam int CNT_W = $clog2(ACT_TIMEOUT + 1);
   localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(ACT_TIMEOUT);

   logic             vsd_sel;
   logic             old_mosi;
   logic             old_miso;
   logic [CNT_W-1:0] idle_cnt;
   logic             sd_act;

   // A mounted image with nonzero size selects the virtual card
   always_ff @(posedge clock_bus) begin
      if (!rst_n)
         vsd_sel <= 1'b0;
      else if (img_mounted)
         vsd_sel <= |img_size;
   end

   // Physical card pins idle while the virtual card is in use
   assign sd_pins.cs   = vsd_sel;
   assign sd_pins.sck  = spi_sck & ~vsd_sel;
   assign sd_pins.mosi = spi_mosi & ~vsd_sel;
   assign spi_miso     = vsd_sel ? virt_miso : card_miso;

   // ============================================================
   // Activity timer
   // ============================================================
   always_ff @(posedge clock_bus) begin
      if (!rst_n) begin
         old_mosi <= 1'b0;
         old_miso <= 1'b0;
         idle_cnt <= CNT_MAX;
         sd_act   <= 1'b0;
      end else begin
         old_mosi <= spi_mosi;
         old_miso <= spi_miso;
         // Saturates so the LED stays dark when the bus is idle
         if ((old_mosi ^ spi_mosi) || (old_miso ^ spi_miso))
            idle_cnt <= '0;
         else if (idle_cnt != CNT_MAX)
            idle_cnt <= idle_cnt + 1'b1;
         sd_act <= (idle_cnt != CNT_MAX);
      end
   end

   assign led_user = vsd_sel & sd_act;
   // Upper bit hands the disk LED fully to the core
   assign led_disk = {1'b1, ~vsd_sel & sd_act};

endmodule

// ==== design/status_decode.sv ====
// Menu status word decode into registered settings and core reset
module status_decode (
   input  logic                                clock_bus,
   input  logic                                rst_n,
   input  logic [core_ctrl_pkg::STATUS_W-1:0]  status,
   input  logic                                ext_reset,
   input  logic                                forced_scandoubler,
   output core_ctrl_pkg::osd_settings_t        settings,
   output logic                                core_reset
);

   core_ctrl_pkg::osd_settings_t settings_next;
   logic                         reset_next;

   // Field extraction
   always_comb begin
      settings_next.aspect =
         core_ctrl_pkg::aspect_e'(status[core_ctrl_pkg::ST_ASPECT +: 2]);
      settings_next.fx =
         core_ctrl_pkg::fx_e'(status[core_ctrl_pkg::ST_FX +: 3]);
      settings_next.scale      = status[core_ctrl_pkg::ST_SCALE +: 2];
      settings_next.vcrop_en   = status[core_ctrl_pkg::ST_VCROP];
      settings_next.tape_src   =
         core_ctrl_pkg::tape_src_e'(status[core_ctrl_pkg::ST_TAPE_SRC]);
      settings_next.rewind_req = status[core_ctrl_pkg::ST_REWIND];
      // Any effect needs the doubled line rate
      settings_next.scandoubler =
         (settings_next.fx != core_ctrl_pkg::FX_NONE) || forced_scandoubler;
   end

   // Menu reset, detach and external reset all restart the core
   assign reset_next = ext_reset
                     | status[core_ctrl_pkg::ST_RESET]
                     | status[core_ctrl_pkg::ST_DETACH];

   always_ff @(posedge clock_bus) begin
      if (!rst_n) begin
         settings   <= '0;
         core_reset <= 1'b0;
      end else begin
         settings   <= settings_next;
         core_reset <= reset_next;
      end
   end

endmodule

// ==== design/tape_control.sv ====
// Cassette load latch, play and rewind control, tape audio source select
module tape_control (
   input  logic                          clock_bus,
   input  logic                          rst_n,
   input  core_ctrl_pkg::osd_settings_t  settings,
   input  logic                          core_reset,
   input  logic                          ioctl_download,
   input  logic [5:0]                    ioctl_index,
   input  logic                          tape_file,
   input  logic                          tape_adc,
   input  logic                          tape_adc_act,
   output logic                          cas_play,
   output logic                          cas_rewind,
   output logic                          tape_audio
);

   logic cas_dl;
   logic cas_dl_last;
   logic cas_load;

   assign cas_dl = ioctl_download && (ioctl_index == core_ctrl_pkg::CAS_INDEX);

   // Latch a loaded tape on the falling edge of its download
   always_ff @(posedge clock_bus) begin
      if (!rst_n) begin
         cas_dl_last <= 1'b0;
         cas_load    <= 1'b0;
      end else begin
         cas_dl_last <= cas_dl;
         if (cas_dl_last && !cas_dl)
            cas_load <= 1'b1;
      end
   end

   // Motor is driven outside this block and counts as on
   assign cas_rewind = settings.rewind_req | cas_dl | core_reset;
   assign cas_play   = cas_load & ~cas_rewind;

   assign tape_audio = (settings.tape_src == core_ctrl_pkg::TAPE_SRC_FILE)
                     ? tape_file
                     : (tape_adc & tape_adc_act);

endmodule

// ==== design/video_geometry.sv ====
// Vertical crop, aspect ratio, scanline and hq2x selection for the HDMI output
module video_geometry (
   input  logic                          clock_bus,
   input  logic                          rst_n,
   input  core_ctrl_pkg::osd_settings_t  settings,
   input  display_pkg::dim_t             hdmi_width,
   input  display_pkg::dim_t             hdmi_height,
   output display_pkg::video_geom_t      geom
);

   logic [12:0]       wide_limit;
   logic              wide_mode;
   logic              tall_mode;
   display_pkg::dim_t crop_next;
   logic              wide_next;
   display_pkg::dim_t crop_q;
   logic              wide_q;

   // Width >= 1.5 x height, kept in 13 bits so tall modes cannot wrap
   assign wide_limit = {1'b0, hdmi_height} + 13'(hdmi_height[11:1]);
   assign wide_mode  = ({1'b0, hdmi_width} >= wide_limit) && !settings.scandoubler;
   assign tall_mode  = (hdmi_width >= display_pkg::TALL_MIN_WIDTH)
                       && !settings.scandoubler;

   // ============================================================
   // Crop lookup
   // ============================================================
   always_comb begin
      crop_next = '0;
      wide_next = 1'b0;
      if (wide_mode) begin
         for (int i = 0; i < display_pkg::WIDE_RULES; i++) begin
            if (hdmi_height == display_pkg::WIDE_CROP_RULES[i].height) begin
               crop_next = display_pkg::WIDE_CROP_RULES[i].lines;
               wide_next = display_pkg::WIDE_CROP_RULES[i].wide_ok & settings.vcrop_en;
            end
         end
      end else if (tall_mode) begin
         for (int i = 0; i < display_pkg::TALL_RULES; i++) begin
            if (hdmi_height == display_pkg::TALL_CROP_RULES[i].height) begin
               crop_next = display_pkg::TALL_CROP_RULES[i].lines;
               wide_next = display_pkg::TALL_CROP_RULES[i].wide_ok & settings.vcrop_en;
            end
         end
      end
   end

   always_ff @(posedge clock_bus) begin
      if (!rst_n) begin
         crop_q <= '0;
         wide_q <= 1'b0;
      end else begin
         crop_q <= crop_next;
         wide_q <= wide_next;
      end
   end

   // ============================================================
   // Output fields
   // ============================================================
   always_comb begin
      if (settings.aspect == core_ctrl_pkg::ASPECT_ORIGINAL) begin
         geom.arx = display_pkg::ARX_ORIGINAL;
         geom.ary = '0;
      end else begin
         geom.arx = wide_q ? display_pkg::ARX_WIDE : display_pkg::ARX_NORMAL;
         geom.ary = display_pkg::ARY_NORMAL;
      end
      geom.crop_size = settings.vcrop_en ? crop_q : '0;
      geom.scale     = {1'b0, settings.scale};
      // CRT25..CRT75 map to scanline levels 1..3
      if (settings.fx > core_ctrl_pkg::FX_HQ2X_160)
         geom.vga_sl = 2'(settings.fx - 3'd2);
      else
         geom.vga_sl = 2'd0;
      geom.hq2x = (settings.fx == core_ctrl_pkg::FX_HQ2X_320)
               || (settings.fx == core_ctrl_pkg::FX_HQ2X_160);
      geom.scandoubler = settings.scandoubler;
   end

endmodule

// ==== msx_core_ctrl.f ====
+incdir+include
design/core_ctrl_pkg.sv
design/display_pkg.sv
design/status_decode.sv
design/video_geometry.sv
design/sd_activity.sv
design/tape_control.sv
design/msx_core_ctrl.sv
tb/tb_msx_core_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary -f msx_core_ctrl.f --top-module tb_msx_core_ctrl -o sim_msx_core_ctrl

sim_rc=0
sim_out=$(./obj_dir/sim_msx_core_ctrl 2>&1) || sim_rc=$?
printf '%s\n' "$sim_out"

if [ "$sim_rc" -eq 0 ] && printf '%s\n' "$sim_out" | grep -qx "Regression passed"; then
   exit 0
else
   exit 1
fi

// ==== include/tb_vectors.svh ====
// Geometry vector table with row type, row count, stimulus and expected video fields
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

   // Row of name, status word, HDMI width, HDMI height, forced scandoubler, expected geom
   typedef struct packed {
      logic [8*12-1:0]                    name;
      logic [core_ctrl_pkg::STATUS_W-1:0] status;
      display_pkg::dim_t                  width;
      display_pkg::dim_t                  height;
      logic                               forced;
      display_pkg::video_geom_t           expected;
   } geom_vec_t;

   localparam int GEOM_VEC_N = 16;

   // Status 64'h0000_0100_0000_0002 is aspect full with vcrop on
   localparam geom_vec_t GEOM_VECS [GEOM_VEC_N] = '{
      '{"wide_480", 64'h0000_0100_0000_0002, 12'd854, 12'd480, 1'b0,
        '{12'd400, 12'd300, 12'd240, 3'd0, 2'd0, 1'b0, 1'b0}},
      '{"wide_600", 64'h0000_0100_0000_0002, 12'd1024, 12'd600, 1'b0,
        '{12'd340, 12'd300, 12'd200, 3'd0, 2'd0, 1'b0, 1'b0}},
      '{"wide_720", 64'h0000_0100_0000_0002, 12'd1280, 12'd720, 1'b0,
        '{12'd400, 12'd300, 12'd240, 3'd0, 2'd0, 1'b0, 1'b0}},
      '{"wide_768", 64'h0000_0100_0000_0002, 12'd1366, 12'd768, 1'b0,
        '{12'd400, 12'd300, 12'd256, 3'd0, 2'd0, 1'b0, 1'b0}},
      '{"wide_800", 64'h0000_0100_0000_0002, 12'd1280, 12'd800, 1'b0,
        '{12'd340, 12'd300, 12'd200, 3'd0, 2'd0, 1'b0, 1'b0}},
      '{"wide_1080", 64'h0000_0100_0000_0002, 12'd1920, 12'd1080, 1'b0,
        '{12'd400, 12'd300, 12'd216, 3'd0, 2'd0, 1'b0, 1'b0}},
      '{"wide_1200", 64'h0000_0100_0000_0002, 12'd1920, 12'd1200, 1'b0,
        '{12'd400, 12'd300, 12'd240, 3'd0, 2'd0, 1'b0, 1'b0}},
      '{"tall_1440", 64'h0000_0100_0000_0002, 12'd1920, 12'd1440, 1'b0,
        '{12'd400, 12'd300, 12'd240, 3'd0, 2'd0, 1'b0, 1'b0}},
      '{"unlisted_900", 64'h0000_0100_0000_0002, 12'd1600, 12'd900, 1'b0,
        '{12'd400, 12'd300, 12'd0, 3'd0, 2'd0, 1'b0, 1'b0}},
      '{"forced_sd", 64'h0000_0100_0000_0002, 12'd1920, 12'd1080, 1'b1,
        '{12'd400, 12'd300, 12'd0, 3'd0, 2'd0, 1'b0, 1'b1}},
      // Effects with original aspect, scandoubler on so no crop
      '{"crt25", 64'h0000_0000_0000_0018, 12'd1920, 12'd1080, 1'b0,
        '{12'd3, 12'd0, 12'd0, 3'd0, 2'd1, 1'b0, 1'b1}},
      '{"crt50", 64'h0000_0000_0000_0020, 12'd1920, 12'd1080, 1'b0,
        '{12'd3, 12'd0, 12'd0, 3'd0, 2'd2, 1'b0, 1'b1}},
      '{"crt75", 64'h0000_0000_0000_0028, 12'd1920, 12'd1080, 1'b0,
        '{12'd3, 12'd0, 12'd0, 3'd0, 2'd3, 1'b0, 1'b1}},
      '{"hq2x_320", 64'h0000_0000_0000_0008, 12'd1920, 12'd1080, 1'b0,
        '{12'd3, 12'd0, 12'd0, 3'd0, 2'd0, 1'b1, 1'b1}},
      '{"hq2x_160", 64'h0000_0000_0000_0010, 12'd1920, 12'd1080, 1'b0,
        '{12'd3, 12'd0, 12'd0, 3'd0, 2'd0, 1'b1, 1'b1}},
      '{"scale_3", 64'h0000_0000_0000_00c0, 12'd1920, 12'd1080, 1'b0,
        '{12'd3, 12'd0, 12'd0, 3'd3, 2'd0, 1'b0, 1'b0}}
   };

`endif

// ==== tb/tb_msx_core_ctrl.sv ====
// Testbench for the MSX core control top level with geometry table, reset, SD and tape checks
module tb_msx_core_ctrl;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int ACT_TIMEOUT = 20;

`include "tb_vectors.svh"

   localparam int WATCHDOG_CYCLES = GEOM_VEC_N * 8 + 6 * ACT_TIMEOUT + 300;
   localparam display_pkg::video_geom_t GEOM_RESET =
      '{12'd3, 12'd0, 12'd0, 3'd0, 2'd0, 1'b0, 1'b0};

   logic                               clock_bus;
   logic                               rst_n;
   logic [core_ctrl_pkg::STATUS_W-1:0] status;
   logic                               ext_reset;
   logic                               forced_scandoubler;
   display_pkg::dim_t                  hdmi_width;
   display_pkg::dim_t                  hdmi_height;
   logic                               img_mounted;
   logic [63:0]                        img_size;
   logic                               spi_sck;
   logic                               spi_mosi;
   logic                               card_miso;
   logic                               virt_miso;
   logic                               ioctl_download;
   logic [5:0]                         ioctl_index;
   logic                               tape_file;
   logic                               tape_adc;
   logic                               tape_adc_act;
   logic                               core_reset;
   display_pkg::video_geom_t           geom;
   core_ctrl_pkg::sd_pins_t            sd_pins;
   logic                               spi_miso;
   logic                               led_user;
   logic [1:0]                         led_disk;
   logic                               cas_play;
   logic                               cas_rewind;
   logic                               tape_audio;

   msx_core_ctrl #(.ACT_TIMEOUT(ACT_TIMEOUT)) u_dut (.*);

   initial begin
      clock_bus = 1'b0;
      forever #5 clock_bus = ~clock_bus;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clock_bus);
      $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Regression failed");
      $fatal(1, "watchdog expired");
   end

   // ============================================================
   // Helpers
   // ============================================================
   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (actual !== expected) begin
         $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
         $display("Regression failed");
         $fatal(1, "value mismatch");
      end
   endtask

   // Let registers update, then sample away from the edge
   task automatic settle(input int cycles);
      repeat (cycles) @(posedge clock_bus);
      @(negedge clock_bus);
   endtask

   function automatic logic probe(input int sel);
      case (sel)
         0:       return led_user;
         1:       return led_disk[0];
         default: return cas_play;
      endcase
   endfunction

   task automatic await_output(input string name, input int sel, input int limit);
      int   n;
      logic seen;
      n = 0;
      seen = 1'b0;
      while (!seen && n < limit) begin
         @(posedge clock_bus);
         @(negedge clock_bus);
         seen = probe(sel);
         n++;
      end
      check_value(name, 1, 64'(seen));
   endtask

   task automatic pulse_reset_source(input string name, input logic [63:0] word,
                                     input logic ext);
      @(posedge clock_bus);
      status    <= word;
      ext_reset <= ext;
      settle(1);
      check_value({name, "_set"}, 1, 64'(core_reset));
      @(posedge clock_bus);
      status    <= '0;
      ext_reset <= 1'b0;
      settle(1);
      check_value({name, "_clear"}, 0, 64'(core_reset));
   endtask

   task automatic mount_image(input logic [63:0] size);
      @(posedge clock_bus);
      img_size    <= size;
      img_mounted <= 1'b1;
      @(posedge clock_bus);
      img_mounted <= 1'b0;
      @(negedge clock_bus);
   endtask

   // One mosi edge lights the LED, which goes dark after the idle timeout
   task automatic check_activity(input string name, input int sel);
      @(posedge clock_bus);
      spi_mosi <= ~spi_mosi;
      await_output({name, "_on"}, sel, 3);
      settle(ACT_TIMEOUT + 5);
      check_value({name, "_off"}, 3'b010, 64'({led_user, led_disk}));
   endtask

   task automatic check_audio(input string name, input logic adc_src, input logic file,
                              input logic adc, input logic act, input logic expected);
      @(posedge clock_bus);
      status       <= 64'(adc_src) << core_ctrl_pkg::ST_TAPE_SRC;
      tape_file    <= file;
      tape_adc     <= adc;
      tape_adc_act <= act;
      settle(1);
      check_value(name, 64'(expected), 64'(tape_audio));
   endtask

   // ============================================================
   // Test sequence
   // ============================================================
   initial begin
      rst_n = 1'b0;
      status = '0;
      ext_reset = 1'b0;
      forced_scandoubler = 1'b0;
      hdmi_width = 12'd1920;
      hdmi_height = 12'd1080;
      img_mounted = 1'b0;
      img_size = '0;
      spi_sck = 1'b0;
      spi_mosi = 1'b0;
      card_miso = 1'b0;
      virt_miso = 1'b0;
      ioctl_download = 1'b0;
      ioctl_index = 6'd0;
      tape_file = 1'b0;
      tape_adc = 1'b0;
      tape_adc_act = 1'b0;
      repeat (3) @(posedge clock_bus);
      rst_n <= 1'b1;
      // LEDs stay dark while the idle counter sits at its limit
      settle(2);
      check_value("reset_leds", 3'b010, 64'({led_user, led_disk}));
      check_value("reset_cas_play", 0, 64'(cas_play));
      check_value("reset_geom", 64'(GEOM_RESET), 64'(geom));

      for (int i = 0; i < GEOM_VEC_N; i++) begin
         @(posedge clock_bus);
         status             <= GEOM_VECS[i].status;
         hdmi_width         <= GEOM_VECS[i].width;
         hdmi_height        <= GEOM_VECS[i].height;
         forced_scandoubler <= GEOM_VECS[i].forced;
         settle(4);
         check_value(string'(GEOM_VECS[i].name), 64'(GEOM_VECS[i].expected), 64'(geom));
      end

      pulse_reset_source("reset_bit", 64'd1 << core_ctrl_pkg::ST_RESET, 1'b0);
      pulse_reset_source("detach_bit", 64'd1 << core_ctrl_pkg::ST_DETACH, 1'b0);
      pulse_reset_source("ext_reset", '0, 1'b1);

      // Virtual card gates the physical pins and routes its own miso
      @(posedge clock_bus);
      spi_sck   <= 1'b1;
      spi_mosi  <= 1'b1;
      virt_miso <= 1'b1;
      mount_image(64'h1000);
      check_value("sd_virtual_pins", 3'b001, 64'(sd_pins));
      check_value("sd_virtual_miso", 1, 64'(spi_miso));
      @(posedge clock_bus);
      card_miso <= 1'b1;
      virt_miso <= 1'b0;
      mount_image('0);
      check_value("sd_card_pins", 3'b110, 64'(sd_pins));
      check_value("sd_card_miso", 1, 64'(spi_miso));

      settle(ACT_TIMEOUT + 5);
      check_value("sd_idle", 3'b010, 64'({led_user, led_disk}));
      check_activity("act_card", 1);
      mount_image(64'h1000);
      settle(ACT_TIMEOUT + 5);
      check_activity("act_virtual", 0);

      @(posedge clock_bus);
      ioctl_index    <= 6'd5;
      ioctl_download <= 1'b1;
      @(negedge clock_bus);
      check_value("cas_dl_rewind", 1, 64'(cas_rewind));
      check_value("cas_dl_play", 0, 64'(cas_play));
      @(posedge clock_bus);
      ioctl_download <= 1'b0;
      await_output("cas_loaded_play", 2, 2);
      @(posedge clock_bus);
      status <= 64'd1 << core_ctrl_pkg::ST_REWIND;
      settle(1);
      check_value("rewind_play", 0, 64'(cas_play));
      check_value("rewind_active", 1, 64'(cas_rewind));
      @(posedge clock_bus);
      status <= '0;
      settle(1);
      check_value("rewind_release", 1, 64'(cas_play));

      check_audio("audio_file_hi", 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
      check_audio("audio_file_lo", 1'b0, 1'b0, 1'b1, 1'b1, 1'b0);
      check_audio("audio_adc_act", 1'b1, 1'b0, 1'b1, 1'b1, 1'b1);
      check_audio("audio_adc_idle", 1'b1, 1'b1, 1'b1, 1'b0, 1'b0);

      $display("Regression passed");
      $finish;
   end

endmodule
